// File: all.f
+incdir+include
design/riscv_pkg.sv
design/lsu_align.sv
design/lsu.sv
design/wb_data_ram.sv
design/lsu_top.sv
test/lsu_tb.sv

// File: Makefile
# Verilator build and run of the load/store testbench

SIM  := obj_dir/Vlsu_tb
SRCS := all.f $(wildcard design/*.sv test/*.sv include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module lsu_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/lsu_tb.sv
// random load/store testbench for lsu_top, every completion is checked against a byte-array model
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_tb;

localparam int MEM_BYTES = `LSU_RAM_WORDS * 4;
localparam int TIMEOUT   = 50;

logic                   clk_i;
logic                   rstn_i;
logic                   req_i;
logic                   we_i;
riscv_pkg::mem_size_e   size_i;
logic                   unsigned_i;
logic [`LSU_XLEN-1:0]   addr_i;
logic [`LSU_XLEN-1:0]   wdata_i;
logic                   done_o;
riscv_pkg::data_word_u  rdata_o;
logic                   stall_o;

// byte image of the RAM
logic [7:0]             model_mem [MEM_BYTES];
// completions still owed, in acceptance order
logic                   exp_is_load [$];
riscv_pkg::data_word_u  exp_data [$];
string                  test_name;

lsu_top uut
(
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .req_i      (req_i),
    .we_i       (we_i),
    .size_i     (size_i),
    .unsigned_i (unsigned_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .done_o     (done_o),
    .rdata_o    (rdata_o),
    .stall_o    (stall_o)
);

always #2 clk_i = ~clk_i;

task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
endtask

task automatic report_timeout(input string what);
    $display("timed out waiting for %s during %s", what, test_name);
    abort_run();
endtask

task automatic check_load(input string name, input riscv_pkg::data_word_u exp,
                          input riscv_pkg::data_word_u act);
    if (act.word !== exp.word)
    begin
        $display("error: %s expected %h actual %h", name, exp.word, act.word);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        $display("error: %s expected %b actual %b", name, exp, act);
        abort_run();
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp)
    begin
        $display("error: %s expected %0d actual %0d", name, exp, act);
        abort_run();
    end
endtask

// value a load should return, built from the little-endian byte image
function automatic riscv_pkg::data_word_u load_value(input riscv_pkg::mem_size_e size,
                                                     input logic uns, input int a);
    riscv_pkg::data_word_u v;
    logic [7:0]  b;
    logic [15:0] h;
    case (size)
        riscv_pkg::MEM_BYTE:
        begin
            b = model_mem[a];
            v.word = uns ? {24'h0, b} : {{24{b[7]}}, b};
        end
        riscv_pkg::MEM_HALF:
        begin
            h = {model_mem[a + 1], model_mem[a]};
            v.word = uns ? {16'h0, h} : {{16{h[15]}}, h};
        end
        default:
            v.word = {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
    endcase
    return v;
endfunction

task automatic store_model(input riscv_pkg::mem_size_e size, input int a, input logic [31:0] d);
    int n;
    n = (size == riscv_pkg::MEM_BYTE) ? 1 : (size == riscv_pkg::MEM_HALF) ? 2 : 4;
    for (int i = 0; i < n; i++)
        model_mem[a + i] = d[8*i +: 8];
endtask

function automatic int rand_addr(input riscv_pkg::mem_size_e size);
    int a;
    a = int'($urandom % MEM_BYTES);
    if (size == riscv_pkg::MEM_HALF)
        a = a & ~1;
    else if (size == riscv_pkg::MEM_WORD)
        a = a & ~3;
    return a;
endfunction

// done_o and rdata_o are registered-path outputs, stable at the falling edge
task automatic collect_done();
    riscv_pkg::data_word_u exp;
    logic                  is_load;
    if (done_o)
    begin
        if (exp_is_load.size() == 0)
        begin
            $display("done_o pulsed with no request outstanding during %s", test_name);
            abort_run();
        end
        else
        begin
            is_load = exp_is_load.pop_front();
            exp = exp_data.pop_front();
            if (is_load)
                check_load(test_name, exp, rdata_o);
        end
    end
endtask

task automatic next_cycle();
    @(negedge clk_i);
    collect_done();
endtask

// drive one request and hold it until accepted, returns the stall cycles seen
task automatic issue(input logic we, input riscv_pkg::mem_size_e size, input logic uns,
                     input int a, input logic [31:0] wdata, output int stalls);
    int   waited;
    logic taken;
    waited = 0;
    while (exp_is_load.size() >= `LSU_MAX_PENDING)
    begin
        req_i = 1'b0;
        next_cycle();
        waited++;
        if (waited > TIMEOUT)
            report_timeout("a free request slot");
    end
    req_i = 1'b1;
    we_i = we;
    size_i = size;
    unsigned_i = uns;
    addr_i = a;
    wdata_i = wdata;
    stalls = 0;
    taken = 1'b0;
    while (!taken)
    begin
        // stall_o depends on the new inputs, let it settle before the rising edge
        #1;
        if (stall_o)
            stalls++;
        else
        begin
            taken = 1'b1;
            exp_is_load.push_back(!we);
            exp_data.push_back(load_value(size, uns, a));
            if (we)
                store_model(size, a, wdata);
        end
        next_cycle();
        if (stalls > TIMEOUT)
            report_timeout("request acceptance");
    end
    req_i = 1'b0;
endtask

task automatic drain();
    int waited;
    waited = 0;
    req_i = 1'b0;
    while (exp_is_load.size() != 0)
    begin
        next_cycle();
        waited++;
        if (waited > TIMEOUT)
            report_timeout("outstanding completions");
    end
endtask

initial
begin
    int                   stalls;
    int                   a;
    riscv_pkg::mem_size_e sz;
    void'($urandom(85229));
    clk_i = 1'b0;
    rstn_i = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    size_i = riscv_pkg::MEM_WORD;
    unsigned_i = 1'b0;
    addr_i = '0;
    wdata_i = '0;
    test_name = "reset";
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;
    check_flag("done_o after reset", 1'b0, done_o);
    check_flag("stall_o after reset", 1'b0, stall_o);

    // first request on an idle bus costs one stall cycle
    test_name = "single held request";
    issue(1'b1, riscv_pkg::MEM_WORD, 1'b0, 0, 32'hcafe_f00d, stalls);
    check_count("first request stall cycles", 1, stalls);
    drain();

    // fill every word, the pattern uses the whole word index
    test_name = "word store and load";
    for (int i = 0; i < `LSU_RAM_WORDS; i++)
        issue(1'b1, riscv_pkg::MEM_WORD, 1'b0, i * 4, 32'(i) * 32'h9e37_79b1 + 32'h0123_4567,
              stalls);
    for (int i = 0; i < `LSU_RAM_WORDS; i++)
        issue(1'b0, riscv_pkg::MEM_WORD, 1'b0, i * 4, 32'h0, stalls);
    drain();

    test_name = "sub-word stores";
    for (int i = 0; i < 64; i++)
    begin
        sz = riscv_pkg::mem_size_e'(2'($urandom % 2));
        a = rand_addr(sz);
        issue(1'b1, sz, 1'b0, a, $urandom, stalls);
        issue(1'b0, riscv_pkg::MEM_WORD, 1'b0, a & ~3, 32'h0, stalls);
    end
    drain();

    test_name = "sub-word loads";
    for (int i = 0; i < 128; i++)
    begin
        sz = riscv_pkg::mem_size_e'(2'($urandom % 2));
        issue(1'b0, sz, 1'(($urandom % 2)), rand_addr(sz), 32'h0, stalls);
    end
    drain();

    test_name = "write to read turnaround";
    a = rand_addr(riscv_pkg::MEM_WORD);
    issue(1'b1, riscv_pkg::MEM_WORD, 1'b0, a, $urandom, stalls);
    issue(1'b0, riscv_pkg::MEM_WORD, 1'b0, a, 32'h0, stalls);
    check_count("read after write stall cycles", 1, stalls);
    issue(1'b0, riscv_pkg::MEM_WORD, 1'b0, a, 32'h0, stalls);
    check_count("read after read stall cycles", 0, stalls);
    drain();

    test_name = "random stream";
    for (int i = 0; i < 2000; i++)
    begin
        if ($urandom % 4 == 0)
        begin
            req_i = 1'b0;
            next_cycle();
        end
        sz = riscv_pkg::mem_size_e'(2'($urandom % 3));
        issue(1'($urandom % 2), sz, 1'($urandom % 2), rand_addr(sz), $urandom, stalls);
    end
    drain();

    $display("ALL TESTS PASSED");
    $finish;
end

endmodule : lsu_tb

`default_nettype wire

// File: design/lsu_top.sv
// data-memory side of the core, joins the align stage, the LSU master and the data RAM
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_top
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    // core load/store port
    input  wire logic                  req_i,
    input  wire logic                  we_i,
    input  wire riscv_pkg::mem_size_e  size_i,
    input  wire logic                  unsigned_i,
    input  wire logic [`LSU_XLEN-1:0]  addr_i,
    input  wire logic [`LSU_XLEN-1:0]  wdata_i,
    output logic                       done_o,
    output riscv_pkg::data_word_u      rdata_o,
    output logic                       stall_o
);

// word port between align stage and LSU
logic                   lsu_req;
logic                   lsu_we;
logic [`LSU_XLEN-1:0]   lsu_addr;
logic [3:0]             lsu_sel;
riscv_pkg::data_word_u  lsu_wdata;
logic                   lsu_done;
riscv_pkg::data_word_u  lsu_rdata;
logic                   lsu_stall;

// Wishbone bus between LSU and RAM
logic                   wb_cyc;
logic                   wb_stb;
logic                   wb_we;
logic [`LSU_XLEN-1:0]   wb_addr;
logic [3:0]             wb_sel;
logic [`LSU_XLEN-1:0]   wb_wdata;
logic                   wb_stall;
logic                   wb_ack;
logic [`LSU_XLEN-1:0]   wb_rdata;

lsu_align u_align
(
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .size_i      (size_i),
    .unsigned_i  (unsigned_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .done_o      (done_o),
    .rdata_o     (rdata_o),
    .stall_o     (stall_o),
    .lsu_req_o   (lsu_req),
    .lsu_we_o    (lsu_we),
    .lsu_addr_o  (lsu_addr),
    .lsu_sel_o   (lsu_sel),
    .lsu_wdata_o (lsu_wdata),
    .lsu_done_i  (lsu_done),
    .lsu_rdata_i (lsu_rdata),
    .lsu_stall_i (lsu_stall)
);

lsu u_lsu
(
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_i       (lsu_req),
    .we_i        (lsu_we),
    .addr_i      (lsu_addr),
    .wsel_byte_i (lsu_sel),
    .wdata_i     (lsu_wdata.word),
    .req_done_o  (lsu_done),
    .rdata_o     (lsu_rdata.word),
    .req_stall_o (lsu_stall),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_addr_o   (wb_addr),
    .wb_sel_o    (wb_sel),
    .wb_wdata_o  (wb_wdata),
    .wb_stall_i  (wb_stall),
    .wb_ack_i    (wb_ack),
    .wb_rdata_i  (wb_rdata)
);

wb_data_ram u_ram
(
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_addr_i   (wb_addr),
    .wb_sel_i    (wb_sel),
    .wb_wdata_i  (wb_wdata),
    .wb_stall_o  (wb_stall),
    .wb_ack_o    (wb_ack),
    .wb_rdata_o  (wb_rdata)
);

endmodule : lsu_top

`default_nettype wire

// File: design/wb_data_ram.sv
// Wishbone B4 pipelined data RAM with byte-enable writes and a write-to-read turnaround stall
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module wb_data_ram
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    input  wire logic                  wb_cyc_i,
    input  wire logic                  wb_stb_i,
    input  wire logic                  wb_we_i,
    input  wire logic [`LSU_XLEN-1:0]  wb_addr_i,
    input  wire logic [3:0]            wb_sel_i,
    input  wire logic [`LSU_XLEN-1:0]  wb_wdata_i,
    output logic                       wb_stall_o,
    output logic                       wb_ack_o,
    output logic [`LSU_XLEN-1:0]       wb_rdata_o
);

localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

logic [`LSU_XLEN-1:0]   mem [`LSU_RAM_WORDS];
logic [IDX_W-1:0]       idx;
logic                   accept;
logic                   wr_prev_q;
riscv_pkg::data_word_u  cur_word;
riscv_pkg::data_word_u  new_word;
riscv_pkg::data_word_u  wdata_w;

// word index from the byte address
assign idx = wb_addr_i[IDX_W+1:2];

// single-port array needs a bubble when a read follows a write
assign wb_stall_o = wb_cyc_i && wb_stb_i && !wb_we_i && wr_prev_q;
assign accept = wb_cyc_i && wb_stb_i && !wb_stall_o;

// byte-lane merge of the store data into the stored word
always_comb
begin
    cur_word.word = mem[idx];
    wdata_w.word = wb_wdata_i;
    new_word = cur_word;
    for (int i = 0; i < 4; i++)
    begin
        if (wb_sel_i[i])
            new_word.bytes[i] = wdata_w.bytes[i];
    end
end

always_ff @(posedge clk_i)
begin
    if (accept && wb_we_i)
        mem[idx] <= new_word.word;
    if (accept && !wb_we_i)
        wb_rdata_o <= mem[idx];
end

always_ff @(posedge clk_i)
begin
    if (!rstn_i)
    begin
        wb_ack_o <= 1'b0;
        wr_prev_q <= 1'b0;
    end
    else
    begin
        wb_ack_o <= accept;
        wr_prev_q <= accept && wb_we_i;
    end
end

// strobe without an open bus cycle is a master protocol error
assert property (@(posedge clk_i) disable iff (!rstn_i) wb_stb_i |-> wb_cyc_i)
    else $error("stb asserted outside a bus cycle");

endmodule : wb_data_ram

`default_nettype wire

// File: design/lsu.sv
// load/store unit, Wishbone B4 pipelined master between the align stage and the data bus
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    // word request port from the align stage
    input  wire logic                  req_i,
    input  wire logic                  we_i,
    input  wire logic [`LSU_XLEN-1:0]  addr_i,
    input  wire logic [3:0]            wsel_byte_i,
    input  wire logic [`LSU_XLEN-1:0]  wdata_i,
    output logic                       req_done_o,
    output logic [`LSU_XLEN-1:0]       rdata_o,
    // current request must be held
    output logic                       req_stall_o,

    // Wishbone master
    output logic                       wb_cyc_o,
    output logic                       wb_stb_o,
    output logic                       wb_we_o,
    output logic [`LSU_XLEN-1:0]       wb_addr_o,
    output logic [3:0]                 wb_sel_o,
    output logic [`LSU_XLEN-1:0]       wb_wdata_o,
    input  wire logic                  wb_stall_i,
    input  wire logic                  wb_ack_i,
    input  wire logic [`LSU_XLEN-1:0]  wb_rdata_i
);

localparam int PEND_W = $clog2(`LSU_MAX_PENDING + 1);

localparam logic [1:0] ST_IDLE = 2'd0;
localparam logic [1:0] ST_REQ  = 2'd1;
localparam logic [1:0] ST_WAIT = 2'd2;

logic [1:0]        state_q;
logic [1:0]        state_d;
logic [PEND_W-1:0] ack_pending_q;
logic [PEND_W-1:0] ack_pending_d;
logic              wb_accept;

// a transfer only counts once the slave has taken it
assign wb_accept = wb_stb_o && !wb_stall_i;

// acks still owed before the bus cycle may end
always_comb
begin
    ack_pending_d = ack_pending_q;
    if (wb_accept)
        ack_pending_d = ack_pending_d + 1'b1;
    if (wb_ack_i)
        ack_pending_d = ack_pending_d - 1'b1;
end

always_ff @(posedge clk_i)
begin
    if (!rstn_i)
        ack_pending_q <= '0;
    else
        ack_pending_q <= ack_pending_d;
end

always_ff @(posedge clk_i)
begin
    if (!rstn_i)
        state_q <= ST_IDLE;
    else
        state_q <= state_d;
end

// master FSM
always_comb
begin
    state_d = state_q;
    req_stall_o = 1'b0;
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;

    case (state_q)
        ST_IDLE:
        begin
            // bus not owned yet, hold the requester for one cycle
            if (req_i)
            begin
                req_stall_o = 1'b1;
                state_d = ST_REQ;
            end
        end

        ST_REQ:
        begin
            wb_cyc_o = 1'b1;
            wb_stb_o = req_i;
            if (req_i && wb_stall_i)
                req_stall_o = 1'b1;
            else if (!req_i)
                state_d = (ack_pending_d == '0) ? ST_IDLE : ST_WAIT;
        end

        ST_WAIT:
        begin
            // only draining acks here
            wb_cyc_o = 1'b1;
            if (req_i)
            begin
                req_stall_o = 1'b1;
                state_d = ST_REQ;
            end
            else if (ack_pending_d == '0)
                state_d = ST_IDLE;
        end

        default:
            state_d = ST_IDLE;
    endcase
end

// request is translated to the bus combinationally
always_comb
begin
    wb_we_o = 1'b0;
    wb_addr_o = '0;
    wb_sel_o = '0;
    wb_wdata_o = '0;
    if (state_q == ST_REQ)
    begin
        wb_we_o = we_i;
        wb_addr_o = addr_i;
        wb_wdata_o = wdata_i;
        // reads always fetch the full word
        wb_sel_o = we_i ? wsel_byte_i : 4'hf;
    end
end

assign req_done_o = wb_ack_i;
assign rdata_o = wb_ack_i ? wb_rdata_i : '0;

// the requester keeps within the outstanding limit
// a new transfer with no ack alongside must find a free slot
assert property (@(posedge clk_i) disable iff (!rstn_i)
    (wb_accept && !wb_ack_i) |-> (ack_pending_q < PEND_W'(`LSU_MAX_PENDING)))
    else $error("too many pending requests");

// every ack must match an accepted transfer
assert property (@(posedge clk_i) disable iff (!rstn_i)
    wb_ack_i |-> (ack_pending_q != '0))
    else $error("ack with nothing pending");

endmodule : lsu

`default_nettype wire

// File: design/lsu_align.sv
// alignment stage between core port and LSU, builds byte selects and extends load data
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_align
(
    input  wire logic                    clk_i,
    input  wire logic                    rstn_i,

    // core side
    input  wire logic                    req_i,
    input  wire logic                    we_i,
    input  wire riscv_pkg::mem_size_e    size_i,
    input  wire logic                    unsigned_i,
    input  wire logic [`LSU_XLEN-1:0]    addr_i,
    input  wire logic [`LSU_XLEN-1:0]    wdata_i,
    output logic                         done_o,
    output riscv_pkg::data_word_u        rdata_o,
    output logic                         stall_o,

    // word side towards the LSU
    output logic                         lsu_req_o,
    output logic                         lsu_we_o,
    output logic [`LSU_XLEN-1:0]         lsu_addr_o,
    output logic [3:0]                   lsu_sel_o,
    output riscv_pkg::data_word_u        lsu_wdata_o,
    input  wire logic                    lsu_done_i,
    input  wire riscv_pkg::data_word_u   lsu_rdata_i,
    input  wire logic                    lsu_stall_i
);

localparam int DEPTH = `LSU_MAX_PENDING;
localparam int CNT_W = $clog2(DEPTH + 1);

logic                  accept;
logic [CNT_W-1:0]      q_cnt;
logic [CNT_W-1:0]      push_idx;
logic [1:0]            q_off  [DEPTH];
riscv_pkg::mem_size_e  q_size [DEPTH];
logic                  q_uns  [DEPTH];
logic [7:0]            ld_byte;
logic [15:0]           ld_half;

assign accept = req_i && !lsu_stall_i;

// handshake passes straight through, the LSU owns the timing
assign lsu_req_o = req_i;
assign lsu_we_o  = we_i;
assign lsu_addr_o = {addr_i[`LSU_XLEN-1:2], 2'b00};
assign done_o  = lsu_done_i;
assign stall_o = lsu_stall_i;

// byte select and lane replication for stores
always_comb
begin
    case (size_i)
        riscv_pkg::MEM_BYTE:
        begin
            lsu_sel_o = 4'b0001 << addr_i[1:0];
            lsu_wdata_o.word = {4{wdata_i[7:0]}};
        end
        riscv_pkg::MEM_HALF:
        begin
            lsu_sel_o = 4'b0011 << {addr_i[1], 1'b0};
            lsu_wdata_o.word = {2{wdata_i[15:0]}};
        end
        default:
        begin
            lsu_sel_o = 4'b1111;
            lsu_wdata_o.word = wdata_i;
        end
    endcase
end

// offset queue, one entry per outstanding request
// the head sits at index 0 and the rest shift down on each done
assign push_idx = q_cnt - CNT_W'(lsu_done_i);

always_ff @(posedge clk_i)
begin
    if (!rstn_i)
        q_cnt <= '0;
    else
        q_cnt <= q_cnt + CNT_W'(accept) - CNT_W'(lsu_done_i);
end

always_ff @(posedge clk_i)
begin
    if (lsu_done_i)
    begin
        for (int i = 0; i < DEPTH - 1; i++)
        begin
            q_off[i]  <= q_off[i+1];
            q_size[i] <= q_size[i+1];
            q_uns[i]  <= q_uns[i+1];
        end
    end
    // push after the shift so a simultaneous pop lands in the right slot
    if (accept)
    begin
        q_off[push_idx]  <= addr_i[1:0];
        q_size[push_idx] <= size_i;
        q_uns[push_idx]  <= unsigned_i;
    end
end

// pick the addressed lanes of the returning word and extend them
assign ld_byte = lsu_rdata_i.bytes[q_off[0]];
assign ld_half = {lsu_rdata_i.bytes[{q_off[0][1], 1'b1}], lsu_rdata_i.bytes[{q_off[0][1], 1'b0}]};

always_comb
begin
    case (q_size[0])
        riscv_pkg::MEM_BYTE:
            rdata_o.word = {{24{!q_uns[0] && ld_byte[7]}}, ld_byte};
        riscv_pkg::MEM_HALF:
            rdata_o.word = {{16{!q_uns[0] && ld_half[15]}}, ld_half};
        default:
            rdata_o.word = lsu_rdata_i.word;
    endcase
end

// misaligned halfword and word accesses are not supported
assert property (@(posedge clk_i) disable iff (!rstn_i)
    req_i |-> !((size_i == riscv_pkg::MEM_HALF && addr_i[0]) ||
                (size_i == riscv_pkg::MEM_WORD && addr_i[1:0] != 2'b00)))
    else $error("misaligned access at address %h", addr_i);

endmodule : lsu_align

`default_nettype wire

// File: design/riscv_pkg.sv
// shared types for the load/store path, referenced by scoped name from RTL and testbench
`default_nettype none

`include "lsu_params.svh"

package riscv_pkg;

    // access size as encoded by the core, funct3[1:0] style
    typedef enum logic [1:0]
    {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_e;

    // one data word, seen either whole or as byte lanes
    // byte 0 is the least significant lane (little endian)
    typedef union packed
    {
        logic [`LSU_XLEN-1:0] word;
        logic [(`LSU_XLEN/8)-1:0][7:0] bytes;
    } data_word_u;

endpackage : riscv_pkg

`default_nettype wire

// File: include/lsu_params.svh
// shared constants for the load/store path, included by every RTL file and the testbench
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_XLEN 32

// data RAM depth in words, only the low address bits select a word
`define LSU_RAM_WORDS 256

// most requests that may be outstanding on the bus at once
// sizes the pending-ack counter and the align offset queue
`define LSU_MAX_PENDING 3

`endif
